/* logic/deconv_defines.svh */
`ifndef DECONV_DEFINES_SVH
`define DECONV_DEFINES_SVH

// pixel and column geometry
`define DC_PIX_WIDTH     16
`define DC_FEAT_LEN      2
`define DC_WEIGHT_LEN    3
`define DC_STRIDE        1

// overlap-add output length: all products minus the overlapped ones
`define DC_N_OUT         (`DC_FEAT_LEN*`DC_WEIGHT_LEN - (`DC_WEIGHT_LEN-`DC_STRIDE)*(`DC_FEAT_LEN-1))

// result columns held in the output queue
`define DC_QUEUE_DEPTH   4

// wishbone word address width
`define DC_WB_ADR_WIDTH  2

`endif

/* logic/deconv_pkg.sv */
`default_nettype none
`include "deconv_defines.svh"

package deconv_pkg;

    ////////////////////////////////////////////////////////////
    // pixel and column types
    ////////////////////////////////////////////////////////////

    typedef logic [`DC_PIX_WIDTH-1:0]   pix_t;
    typedef logic [2*`DC_PIX_WIDTH-1:0] acc_t;

    // index 0 is the first pixel pushed
    typedef pix_t [`DC_WEIGHT_LEN-1:0] weight_col_t;
    typedef pix_t [`DC_FEAT_LEN-1:0]   feature_col_t;
    typedef acc_t [`DC_N_OUT-1:0]      result_col_t;

    ////////////////////////////////////////////////////////////
    // wishbone classic
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                        cyc;
        logic                        stb;
        logic                        we;
        logic [`DC_WB_ADR_WIDTH-1:0] adr;
        logic [2*`DC_PIX_WIDTH-1:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic                       ack;
        logic [2*`DC_PIX_WIDTH-1:0] dat;
    } wb_rsp_t;

    // word address map
    typedef enum logic [`DC_WB_ADR_WIDTH-1:0] {
        WEIGHT_PUSH  = 2'd0,
        FEATURE_PUSH = 2'd1,
        STATUS       = 2'd2,
        RESULT       = 2'd3
    } wb_reg_e;

    typedef enum logic {
        BANK_FILL = 1'b0,
        BANK_FULL = 1'b1
    } bank_state_e;

endpackage

`default_nettype wire

/* logic/deconv_wb_slave.sv */
`default_nettype none
`include "deconv_defines.svh"

module deconv_wb_slave
(
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire deconv_pkg::wb_req_t  i_wb,
    output deconv_pkg::wb_rsp_t       o_wb,
    output logic                      o_weight_push,
    output logic                      o_feature_push,
    output deconv_pkg::pix_t          o_pix,
    output logic                      o_result_pop,
    input  wire logic                 i_feature_accept,
    input  wire logic                 i_weight_valid,
    input  wire logic                 i_result_avail,
    input  wire deconv_pkg::acc_t     i_result_pix
);

    deconv_pkg::wb_reg_e reg_sel;
    logic                ack_q;
    logic                req;
    logic                ready;
    deconv_pkg::acc_t    rd_dat;

    assign reg_sel = deconv_pkg::wb_reg_e'(i_wb.adr);

    // new request only outside the ack cycle
    assign req = i_wb.cyc && i_wb.stb && !ack_q;

    // wait states: no bank filling, or nothing to read
    always_comb
    begin
        ready = 1'b1;
        if (i_wb.we && reg_sel == deconv_pkg::FEATURE_PUSH)
            ready = i_feature_accept;
        if (!i_wb.we && reg_sel == deconv_pkg::RESULT)
            ready = i_result_avail;
    end

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            ack_q <= 1'b0;
        else
            ack_q <= req && ready;
    end

    ////////////////////////////////////////////////////////////
    // strobes, valid in the ack cycle only
    ////////////////////////////////////////////////////////////

    assign o_weight_push  = ack_q && i_wb.we && reg_sel == deconv_pkg::WEIGHT_PUSH;
    assign o_feature_push = ack_q && i_wb.we && reg_sel == deconv_pkg::FEATURE_PUSH;
    assign o_result_pop   = ack_q && !i_wb.we && reg_sel == deconv_pkg::RESULT;
    assign o_pix          = i_wb.dat[`DC_PIX_WIDTH-1:0];

    // read mux, status bits are avail / weights held / accepting
    always_comb
    begin
        rd_dat = '0;
        case (reg_sel)
            deconv_pkg::STATUS:
            begin
                rd_dat[0] = i_result_avail;
                rd_dat[1] = i_weight_valid;
                rd_dat[2] = i_feature_accept;
            end
            deconv_pkg::RESULT:
                rd_dat = i_result_pix;
            default:
                rd_dat = '0;
        endcase
    end

    assign o_wb = '{ack: ack_q, dat: (ack_q && !i_wb.we) ? rd_dat : '0};

    a_ack_with_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_wb.ack |-> (i_wb.cyc && i_wb.stb));

endmodule

`default_nettype wire

/* logic/weight_col_loader.sv */
`default_nettype none
`include "deconv_defines.svh"

module weight_col_loader
(
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire logic                   i_push,
    input  wire deconv_pkg::pix_t       i_pix,
    output deconv_pkg::weight_col_t     o_weight_col,
    output logic                        o_weight_valid
);

    localparam int LAST = `DC_WEIGHT_LEN - 1;

    logic [$clog2(`DC_WEIGHT_LEN)-1:0]     cnt;
    deconv_pkg::pix_t [`DC_WEIGHT_LEN-2:0] stage;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            cnt            <= '0;
            o_weight_valid <= 1'b0;
        end
        else if (i_push)
        begin
            if (cnt == LAST)
            begin
                cnt            <= '0;
                o_weight_valid <= 1'b1;
            end
            else
            begin
                cnt <= cnt + 1'b1;
                // a new set invalidates the held column
                if (cnt == 0)
                    o_weight_valid <= 1'b0;
            end
        end
    end

    // staging, then the whole column at once on the last pixel
    always_ff @(posedge i_clk)
    begin
        if (i_push && cnt != LAST)
            stage[cnt] <= i_pix;
        if (i_push && cnt == LAST)
            o_weight_col <= {i_pix, stage};
    end

endmodule

`default_nettype wire

/* logic/feature_pingpong.sv */
`default_nettype none
`include "deconv_defines.svh"

module feature_pingpong
(
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire logic                 i_push,
    input  wire deconv_pkg::pix_t     i_pix,
    output logic                      o_accept,
    input  wire logic                 i_weight_valid,
    input  wire logic                 i_slot_free,
    output logic                      o_issue,
    output deconv_pkg::feature_col_t  o_feature_col
);

    localparam int LAST = `DC_FEAT_LEN - 1;

    deconv_pkg::feature_col_t        bank [2];
    deconv_pkg::bank_state_e         state [2];
    logic                            wr_ptr;
    logic                            rd_ptr;
    logic [$clog2(`DC_FEAT_LEN)-1:0] wr_idx;
    logic [1:0]                      wr_act;

    assign o_accept = (state[wr_ptr] == deconv_pkg::BANK_FILL);

    // one-hot write activate per bank
    assign wr_act = {2{i_push && o_accept}} & (wr_ptr ? 2'b10 : 2'b01);

    assign o_issue       = (state[rd_ptr] == deconv_pkg::BANK_FULL) && i_weight_valid
                           && i_slot_free;
    assign o_feature_col = bank[rd_ptr];

    always_ff @(posedge i_clk)
    begin
        for (int b = 0; b < 2; b++)
        begin
            if (wr_act[b])
                bank[b][wr_idx] <= i_pix;
        end
    end

    ////////////////////////////////////////////////////////////
    // bank states and pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state[0] <= deconv_pkg::BANK_FILL;
            state[1] <= deconv_pkg::BANK_FILL;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            wr_idx   <= '0;
        end
        else
        begin
            if (wr_act != 2'b00)
            begin
                if (wr_idx == LAST)
                begin
                    state[wr_ptr] <= deconv_pkg::BANK_FULL;
                    wr_ptr        <= ~wr_ptr;
                    wr_idx        <= '0;
                end
                else
                    wr_idx <= wr_idx + 1'b1;
            end
            // read bank is never the one being filled
            if (o_issue)
            begin
                state[rd_ptr] <= deconv_pkg::BANK_FILL;
                rd_ptr        <= ~rd_ptr;
            end
        end
    end

    a_no_push_when_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_push && state[0] == deconv_pkg::BANK_FULL && state[1] == deconv_pkg::BANK_FULL));

endmodule

`default_nettype wire

/* logic/deconv_col_engine.sv */
`default_nettype none
`include "deconv_defines.svh"

module deconv_col_engine
(
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_issue,
    input  wire deconv_pkg::feature_col_t i_feature_col,
    input  wire deconv_pkg::weight_col_t i_weight_col,
    output logic                         o_valid,
    output deconv_pkg::result_col_t      o_result_col
);

    // products indexed [feature][weight]
    deconv_pkg::acc_t [`DC_FEAT_LEN-1:0][`DC_WEIGHT_LEN-1:0] prod_q;
    deconv_pkg::result_col_t                                 sum;
    logic                                                    s1_valid;

    ////////////////////////////////////////////////////////////
    // valid pipe
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            s1_valid <= 1'b0;
            o_valid  <= 1'b0;
        end
        else
        begin
            s1_valid <= i_issue;
            o_valid  <= s1_valid;
        end
    end

    ////////////////////////////////////////////////////////////
    // stage 1: all pixel products
    ////////////////////////////////////////////////////////////

    always_ff @(posedge i_clk)
    begin
        if (i_issue)
        begin
            for (int i = 0; i < `DC_FEAT_LEN; i++)
            begin
                for (int j = 0; j < `DC_WEIGHT_LEN; j++)
                    prod_q[i][j] <= i_weight_col[j] * i_feature_col[i];
            end
        end
    end

    // stage 2: output k collects every product with i*stride + j == k
    always_comb
    begin
        sum = '0;
        for (int i = 0; i < `DC_FEAT_LEN; i++)
        begin
            for (int j = 0; j < `DC_WEIGHT_LEN; j++)
                sum[i*`DC_STRIDE + j] = sum[i*`DC_STRIDE + j] + prod_q[i][j];
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (s1_valid)
            o_result_col <= sum;
    end

endmodule

`default_nettype wire

/* logic/result_queue.sv */
`default_nettype none
`include "deconv_defines.svh"

module result_queue
(
    input  wire logic                     i_clk,
    input  wire logic                     i_rst_n,
    input  wire logic                     i_issue,
    input  wire logic                     i_valid,
    input  wire deconv_pkg::result_col_t  i_result_col,
    input  wire logic                     i_pop,
    output logic                          o_slot_free,
    output logic                          o_avail,
    output deconv_pkg::acc_t              o_head_pix
);

    localparam int AW = $clog2(`DC_QUEUE_DEPTH);
    localparam int CW = $clog2(`DC_QUEUE_DEPTH + 1);
    localparam int PW = $clog2(`DC_N_OUT);

    deconv_pkg::result_col_t mem [`DC_QUEUE_DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [CW-1:0]           stored;
    logic [CW-1:0]           reserved;
    logic [CW:0]             occupied;
    logic [PW-1:0]           pix_idx;
    logic                    col_pop;

    // results still in the engine count against the depth
    assign occupied    = {1'b0, stored} + {1'b0, reserved};
    assign o_slot_free = occupied < (CW+1)'(`DC_QUEUE_DEPTH);
    assign o_avail     = (stored != 0);
    assign o_head_pix  = mem[rd_ptr][pix_idx];
    assign col_pop     = i_pop && o_avail && (pix_idx == `DC_N_OUT - 1);

    always_ff @(posedge i_clk)
    begin
        if (i_valid)
            mem[wr_ptr] <= i_result_col;
    end

    // pointers wrap on a power-of-two depth
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            stored   <= '0;
            reserved <= '0;
            pix_idx  <= '0;
        end
        else
        begin
            if (i_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_pop && o_avail)
                pix_idx <= col_pop ? '0 : pix_idx + 1'b1;
            if (col_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (i_valid && !col_pop)
                stored <= stored + 1'b1;
            else if (!i_valid && col_pop)
                stored <= stored - 1'b1;
            if (i_issue && !i_valid)
                reserved <= reserved + 1'b1;
            else if (!i_issue && i_valid)
                reserved <= reserved - 1'b1;
        end
    end

    a_no_write_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_valid && stored == `DC_QUEUE_DEPTH));

endmodule

`default_nettype wire

/* logic/deconv_top.sv */
`default_nettype none

module deconv_top
(
    input  wire logic                 i_clk,
    input  wire logic                 i_rst_n,
    input  wire deconv_pkg::wb_req_t  i_wb,
    output deconv_pkg::wb_rsp_t       o_wb
);

    logic                     weight_push;
    logic                     feature_push;
    deconv_pkg::pix_t         push_pix;
    logic                     result_pop;
    logic                     feature_accept;
    deconv_pkg::weight_col_t  weight_col;
    logic                     weight_valid;
    logic                     slot_free;
    logic                     issue;
    deconv_pkg::feature_col_t feature_col;
    logic                     result_valid;
    deconv_pkg::result_col_t  result_col;
    logic                     result_avail;
    deconv_pkg::acc_t         head_pix;

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////

    deconv_wb_slave u_slave (
        .i_clk            (i_clk),
        .i_rst_n          (i_rst_n),
        .i_wb             (i_wb),
        .o_wb             (o_wb),
        .o_weight_push    (weight_push),
        .o_feature_push   (feature_push),
        .o_pix            (push_pix),
        .o_result_pop     (result_pop),
        .i_feature_accept (feature_accept),
        .i_weight_valid   (weight_valid),
        .i_result_avail   (result_avail),
        .i_result_pix     (head_pix)
    );

    weight_col_loader u_loader (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_push         (weight_push),
        .i_pix          (push_pix),
        .o_weight_col   (weight_col),
        .o_weight_valid (weight_valid)
    );

    feature_pingpong u_pingpong (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_push         (feature_push),
        .i_pix          (push_pix),
        .o_accept       (feature_accept),
        .i_weight_valid (weight_valid),
        .i_slot_free    (slot_free),
        .o_issue        (issue),
        .o_feature_col  (feature_col)
    );

    ////////////////////////////////////////////////////////////
    // compute and output
    ////////////////////////////////////////////////////////////

    deconv_col_engine u_engine (
        .i_clk         (i_clk),
        .i_rst_n       (i_rst_n),
        .i_issue       (issue),
        .i_feature_col (feature_col),
        .i_weight_col  (weight_col),
        .o_valid       (result_valid),
        .o_result_col  (result_col)
    );

    result_queue u_queue (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_issue      (issue),
        .i_valid      (result_valid),
        .i_result_col (result_col),
        .i_pop        (result_pop),
        .o_slot_free  (slot_free),
        .o_avail      (result_avail),
        .o_head_pix   (head_pix)
    );

endmodule

`default_nettype wire

/* verif/tb_deconv.sv */
`default_nettype none
`include "deconv_defines.svh"

module tb_deconv;

    localparam int N_COLUMNS       = 22;
    localparam int WATCHDOG_CYCLES = 200 * N_COLUMNS + 2000;
    localparam int ACK_LIMIT       = 64;

    logic                clk;
    logic                rst_n;
    deconv_pkg::wb_req_t wb_req;
    deconv_pkg::wb_rsp_t wb_rsp;

    integer      seed = 32'h428f9baa;
    int          errors = 0;
    int          checks = 0;
    logic [15:0] model_w [`DC_WEIGHT_LEN];
    logic [31:0] exp_q [$];

    deconv_top dut0 (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_wb    (wb_req),
        .o_wb    (wb_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // watchdog sized from the number of columns pushed
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////

    // one classic cycle, request held until ack is seen
    task automatic wb_cycle(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat);
        bit got_ack;
        int waited;
        got_ack = 1'b0;
        waited  = 0;
        rdat    = '0;
        wb_req  = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        while (!got_ack && waited < ACK_LIMIT)
        begin
            @(posedge clk);
            #1;
            got_ack = wb_rsp.ack;
            rdat    = wb_rsp.dat;
            waited++;
        end
        if (!got_ack)
        begin
            errors++;
            $display("no ack for %s at address %0d within %0d cycles",
                     we ? "write" : "read", adr, ACK_LIMIT);
            wb_req = '0;
            #1;
        end
        else
        begin
            // keep the request through the ack cycle
            @(posedge clk);
            #2;
            wb_req = '0;
        end
    endtask

    task automatic wb_write(input logic [1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, '0, dat);
    endtask

    ////////////////////////////////////////////////////////////
    // model and checking tasks
    ////////////////////////////////////////////////////////////

    function automatic logic [15:0] rand_pix();
        return 16'($random(seed));
    endfunction

    task automatic push_weights(input logic [15:0] w0, input logic [15:0] w1,
                                input logic [15:0] w2);
        wb_write(deconv_pkg::WEIGHT_PUSH, {16'h0, w0});
        wb_write(deconv_pkg::WEIGHT_PUSH, {16'h0, w1});
        wb_write(deconv_pkg::WEIGHT_PUSH, {16'h0, w2});
        model_w[0] = w0;
        model_w[1] = w1;
        model_w[2] = w2;
    endtask

    // out[k] sums f[i]*w[j] over i*stride + j == k
    task automatic push_feature(input logic [15:0] f0, input logic [15:0] f1);
        logic [15:0] f [`DC_FEAT_LEN];
        logic [31:0] acc;
        f[0] = f0;
        f[1] = f1;
        wb_write(deconv_pkg::FEATURE_PUSH, {16'h0, f0});
        wb_write(deconv_pkg::FEATURE_PUSH, {16'h0, f1});
        for (int k = 0; k < `DC_N_OUT; k++)
        begin
            acc = '0;
            for (int i = 0; i < `DC_FEAT_LEN; i++)
            begin
                for (int j = 0; j < `DC_WEIGHT_LEN; j++)
                begin
                    if (i * `DC_STRIDE + j == k)
                        acc = acc + 32'(model_w[j]) * 32'(f[i]);
                end
            end
            exp_q.push_back(acc);
        end
    endtask

    task automatic check_column();
        logic [31:0] got;
        logic [31:0] exp;
        for (int k = 0; k < `DC_N_OUT; k++)
        begin
            wb_read(deconv_pkg::RESULT, got);
            checks++;
            if (exp_q.size() == 0)
            begin
                errors++;
                $display("result read with no column expected");
            end
            else
            begin
                exp = exp_q.pop_front();
                if (got !== exp)
                begin
                    errors++;
                    $display("Fail o_wb.dat pixel %0d: got %h, expected %h", k, got, exp);
                end
            end
        end
    endtask

    task automatic check_status(input logic [2:0] exp, input logic [2:0] mask);
        logic [31:0] got;
        wb_read(deconv_pkg::STATUS, got);
        checks++;
        if ((got & {29'h0, mask}) !== {29'h0, exp & mask})
        begin
            errors++;
            $display("Fail o_wb.dat (status): got %h, expected %h under mask %h",
                     got, exp, mask);
        end
    endtask

    // feature push with both banks full waits without ack, then is withdrawn
    task automatic expect_push_stall(input int cycles);
        int acked;
        acked  = 0;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: deconv_pkg::FEATURE_PUSH, dat: '0};
        repeat (cycles)
        begin
            @(posedge clk);
            #1;
            if (wb_rsp.ack)
                acked++;
        end
        #1;
        wb_req = '0;
        checks++;
        if (acked != 0)
        begin
            errors++;
            $display("feature push was acked while both banks were full");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        wb_req = '0;
        rst_n  = 1'b0;
        repeat (2) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // only the accept bit after reset
        check_status(3'b100, 3'b111);

        // single column
        push_weights(16'h0003, 16'h0005, 16'h0007);
        push_feature(16'h0002, 16'h0004);
        check_column();
        check_status(3'b000, 3'b001);

        // weight reuse across three columns
        push_weights(16'h1234, 16'hfedc, 16'h00ff);
        push_feature(16'h0101, 16'h8000);
        push_feature(16'hffff, 16'hffff);
        push_feature(16'h0010, 16'h0abc);
        repeat (3) check_column();

        // six columns with no reads fill the queue and both banks
        repeat (6) push_feature(rand_pix(), rand_pix());
        check_status(3'b011, 3'b111);
        expect_push_stall(8);
        repeat (6) check_column();

        // new weights apply only to columns pushed after the set completes
        push_weights(16'h0011, 16'h0022, 16'h0033);
        push_feature(16'h0100, 16'h0200);
        wb_write(deconv_pkg::WEIGHT_PUSH, 32'h0000_0009);
        check_status(3'b000, 3'b010);
        wb_write(deconv_pkg::WEIGHT_PUSH, 32'h0000_000a);
        wb_write(deconv_pkg::WEIGHT_PUSH, 32'h0000_000b);
        model_w[0] = 16'h0009;
        model_w[1] = 16'h000a;
        model_w[2] = 16'h000b;
        check_status(3'b010, 3'b010);
        push_feature(16'h0300, 16'h0400);
        repeat (2) check_column();

        // random columns with occasional reloads
        for (int n = 0; n < 10; n++)
        begin
            if (($random(seed) & 3) == 0)
                push_weights(rand_pix(), rand_pix(), rand_pix());
            push_feature(rand_pix(), rand_pix());
            check_column();
        end

        if (exp_q.size() != 0)
        begin
            errors++;
            $display("%0d expected result pixels were never read", exp_q.size());
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+logic
logic/deconv_pkg.sv
logic/deconv_wb_slave.sv
logic/weight_col_loader.sv
logic/feature_pingpong.sv
logic/deconv_col_engine.sv
logic/result_queue.sv
logic/deconv_top.sv
verif/tb_deconv.sv
